/* testbench/csrTrace.txt */
# we op num data tv cause pc daddr cn iw ira rt re ev expRead expTarget iv ic iaddr
# all hex; rnd as data draws an LFSR word, rnd as expRead expects the last random result
0 0 300 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 304 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 305 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 340 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 341 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 342 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 343 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 344 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 b03 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 b00 0 0 0 0 0 0 0 0 0 0 0 a 0 0 0 0
0 0 b02 0 0 0 0 0 3 0 0 0 0 0 0 0 0 0 0
0 0 b02 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0
0 0 b02 0 0 0 0 0 1 0 0 0 0 0 3 0 0 0 0
0 0 b02 0 0 0 0 0 0 0 0 0 0 0 5 0 0 0 0
0 0 b02 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0
0 0 b00 0 0 0 0 0 0 0 0 0 0 0 10 0 0 0 0
1 0 340 12345678 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 340 f0000000 0 0 0 0 0 0 0 0 0 0 12345678 0 0 0 0
1 2 340 78 0 0 0 0 0 0 0 0 0 0 f2345678 0 0 0 0
0 0 340 0 0 0 0 0 0 0 0 0 0 0 f2345600 0 0 0 0
1 0 305 80000103 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 305 0 0 0 0 0 0 0 0 0 0 0 80000103 80000100 0 0 0
1 2 305 3 0 0 0 0 0 0 0 0 0 0 80000103 80000100 0 0 0
0 0 305 0 0 0 0 0 0 0 0 0 0 0 80000100 80000100 0 0 0
1 0 341 2003 0 0 0 0 0 0 0 0 0 0 0 80000100 0 0 0
0 0 341 0 0 0 0 0 0 0 0 0 0 0 2002 80000100 0 0 0
1 0 344 ffffffff 0 0 0 0 0 0 0 0 0 0 0 80000100 0 0 0
1 0 7c0 ffffffff 0 0 0 0 0 0 0 0 0 0 0 80000100 0 0 0
0 0 344 0 0 0 0 0 0 0 0 0 0 0 0 80000100 0 0 0
0 0 340 0 0 0 0 0 0 0 0 0 0 0 f2345600 80000100 0 0 0
1 0 340 rnd 0 0 0 0 0 0 0 0 0 0 f2345600 80000100 0 0 0
1 1 340 rnd 0 0 0 0 0 0 0 0 0 0 rnd 80000100 0 0 0
0 0 340 0 0 0 0 0 0 0 0 0 0 0 rnd 80000100 0 0 0
1 0 341 rnd 0 0 0 0 0 0 0 0 0 0 2002 80000100 0 0 0
0 0 341 0 0 0 0 0 0 0 0 0 0 0 rnd 80000100 0 0 0
1 0 300 8 0 0 0 0 0 0 0 0 0 0 0 80000100 0 0 0
0 0 300 0 0 0 0 0 0 0 0 0 0 0 8 80000100 0 0 0
0 0 342 0 1 5 1040 abcd0001 0 0 0 0 0 0 0 80000100 0 0 0
0 0 341 0 0 0 0 0 0 0 0 0 0 0 1040 80000100 0 0 0
0 0 343 0 0 0 0 0 0 0 0 0 0 0 abcd0001 80000100 0 0 0
0 0 342 0 0 0 0 0 0 0 0 0 0 0 6 80000100 0 0 0
0 0 300 0 0 0 0 0 0 0 0 0 0 0 80 80000100 0 0 0
0 0 300 0 1 2 0 0 0 0 0 0 0 0 80 1040 0 0 0
0 0 300 0 0 0 0 0 0 0 0 0 0 0 88 80000100 0 0 0
0 0 300 0 1 0 2000 0 0 0 0 0 0 0 88 80000100 0 0 0
0 0 342 0 0 0 0 0 0 0 0 0 0 0 b 80000100 0 0 0
1 0 304 880 0 0 0 0 0 0 0 0 0 0 0 80000100 0 0 0
1 0 300 8 0 0 0 0 0 0 0 0 0 0 80 80000100 0 0 0
0 0 344 0 0 0 0 0 0 1 3000 1 0 0 0 80000100 0 0 0
0 0 344 0 0 0 0 0 0 1 3000 1 0 0 80 80000100 1 7 3000
0 0 342 0 0 0 0 0 0 1 0 0 0 0 80000007 80000100 0 0 0
0 0 341 0 0 0 0 0 0 0 0 0 0 0 3000 80000100 0 0 0
0 0 300 0 1 2 0 0 0 0 0 0 0 0 80 3000 0 0 0
0 0 300 0 0 0 0 0 0 0 0 1 1 0 88 80000100 0 0 0
0 0 344 0 0 0 0 0 0 1 3400 1 1 0 880 80000100 1 b 3400
0 0 342 0 0 0 0 0 0 1 0 0 0 0 8000000b 80000100 0 0 0
0 0 300 0 1 2 0 0 0 0 0 0 0 0 80 3400 0 0 0
0 0 300 0 0 0 0 0 0 0 0 1 0 0 88 80000100 0 0 0
1 0 343 11111111 1 3 5000 5004 0 1 3800 0 0 0 3400 80000100 1 7 3800
0 0 343 0 0 0 0 0 0 0 0 0 0 0 3800 80000100 0 0 0
0 0 342 0 0 0 0 0 0 0 0 0 0 0 80000007 80000100 0 0 0
0 0 341 0 0 0 0 0 0 0 0 0 0 0 3800 80000100 0 0 0
0 0 b03 0 0 0 0 0 0 0 0 0 0 8 0 80000100 0 0 0
0 0 b03 0 0 0 0 0 0 0 0 0 0 8 1 80000100 0 0 0
0 0 b03 0 0 0 0 0 0 0 0 0 0 9 2 80000100 0 0 0
0 0 b03 0 0 0 0 0 0 0 0 0 0 0 3 80000100 0 0 0
0 0 b06 0 0 0 0 0 0 0 0 0 0 0 1 80000100 0 0 0
0 0 b04 0 0 0 0 0 0 0 0 0 0 6 0 80000100 0 0 0
0 0 b04 0 0 0 0 0 0 0 0 0 0 0 1 80000100 0 0 0
0 0 b05 0 0 0 0 0 0 0 0 0 0 0 1 80000100 0 0 0
1 0 b00 100 0 0 0 0 0 0 0 0 0 0 47 80000100 0 0 0
0 0 b00 0 0 0 0 0 0 0 0 0 0 0 100 80000100 0 0 0
0 0 b00 0 0 0 0 0 0 0 0 0 0 0 101 80000100 0 0 0
0 0 b02 0 0 0 0 0 0 0 0 0 0 0 6 80000100 0 0 0

/* filelist.f */
source/csrPkg.sv
source/csrFile.sv
source/interruptArbiter.sv
source/perfCounterBank.sv
source/csrSubsystem.sv
testbench/csrSubsystemTb.sv

/* Bender.yml */
package:
  name: csr_subsystem

sources:
  - source/csrPkg.sv
  - source/csrFile.sv
  - source/interruptArbiter.sv
  - source/perfCounterBank.sv
  - source/csrSubsystem.sv
  - target: test
    files:
      - testbench/csrSubsystemTb.sv

/* testbench/csrSubsystemTb.sv */
/*
 * Trace-driven testbench for the CSR subsystem.
 * Reads one stimulus line per cycle from the trace file, drives it on the rising edge
 * and checks readData, targetAddr, intTaken, csrWhole and extIntCodeOut after the
 * falling edge. The external interrupt code is driven from the LFSR.
 */
`default_nettype none

module csrSubsystemTb
    import csrPkg::*;
();

    localparam int clkPeriod = 100;
    localparam int resetCycles = 10;
    localparam logic [31:0] lfsrSeed = 32'heca1;
    localparam string traceFile = "testbench/csrTrace.txt";

    // One parsed trace line
    typedef struct packed {
        csrReqT               csrReq;
        logic                 dataIsRnd;
        trapReqT              trapReq;
        commitCountT          commitNum;
        logic                 intWindow;
        logic [dataWidth-1:0] intRetAddr;
        logic                 reqTimerInt;
        logic                 reqExtInt;
        perfEventT            perfEvent;
        logic [dataWidth-1:0] expRead;
        logic                 expReadIsRnd;
        logic [dataWidth-1:0] expTarget;
        intReqT               expInt;
    } traceLineT;

    logic clk;
    logic rstN;
    csrReqT csrReq;
    trapReqT trapReq;
    commitCountT commitNum;
    logic intWindow;
    logic [dataWidth-1:0] intRetAddr;
    logic reqTimerInt;
    logic reqExtInt;
    extIntCodeT extIntCode;
    perfEventT perfEvent;
    logic [dataWidth-1:0] readData;
    logic [dataWidth-1:0] targetAddr;
    csrBodyT csrWhole;
    intReqT intTaken;
    extIntCodeT extIntCodeOut;

    traceLineT trace[$];
    logic traceLoaded = 1'b0;
    logic [31:0] lfsrState = lfsrSeed;
    int lineIndex = 0;

    csrSubsystem i_csrSubsystem (
        .clk           (clk),
        .rstN          (rstN),
        .csrReq        (csrReq),
        .trapReq       (trapReq),
        .commitNum     (commitNum),
        .intWindow     (intWindow),
        .intRetAddr    (intRetAddr),
        .reqTimerInt   (reqTimerInt),
        .reqExtInt     (reqExtInt),
        .extIntCode    (extIntCode),
        .perfEvent     (perfEvent),
        .readData      (readData),
        .targetAddr    (targetAddr),
        .csrWhole      (csrWhole),
        .intTaken      (intTaken),
        .extIntCodeOut (extIntCodeOut)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    task automatic drawRandomWord(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrNext(lfsrState);
            word = {word[30:0], lfsrState[0]};
        end
    endtask

    task automatic drawRandomCode(output extIntCodeT code);
        code = '0;
        for (int i = 0; i < 4; i++) begin
            lfsrState = lfsrNext(lfsrState);
            code = {code[2:0], lfsrState[0]};
        end
    endtask

    // New CSR value from the old one and the operand
    function automatic logic [31:0] expectedWriteResult(csrOpT op, csrNumT num,
                                                         logic [31:0] old, logic [31:0] operand);
        logic [31:0] result;
        case (op)
            csrOpSet:   result = old | operand;
            csrOpClear: result = old & ~operand;
            default:    result = operand;
        endcase
        if (num == csrNumMepc) begin
            result[0] = 1'b0;
        end
        return result;
    endfunction

    task automatic reportMismatch(string sigName, logic [31:0] got, logic [31:0] expected);
        $display("Fail %s at trace line %0d: got %h, expected %h", sigName, lineIndex, got,
                 expected);
        $display("tests failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic compareData(string sigName, logic [dataWidth-1:0] got,
                               logic [dataWidth-1:0] expected);
        if (got !== expected) begin
            reportMismatch(sigName, got, expected);
        end
    endtask

    task automatic compareAddr(logic [dataWidth-1:0] got, logic [dataWidth-1:0] expected);
        if (got !== expected) begin
            reportMismatch("targetAddr", got, expected);
        end
    endtask

    // Code and return address only matter when an interrupt is taken
    task automatic compareInt(intReqT got, intReqT expected);
        if (got.valid !== expected.valid) begin
            reportMismatch("intTaken.valid", 32'(got.valid), 32'(expected.valid));
        end else if (expected.valid && got.code !== expected.code) begin
            reportMismatch("intTaken.code", 32'(got.code), 32'(expected.code));
        end else if (expected.valid && got.retAddr !== expected.retAddr) begin
            reportMismatch("intTaken.retAddr", got.retAddr, expected.retAddr);
        end
    endtask

    // The register body field of the CSR being read must hold the expected value
    task automatic compareWhole(csrBodyT got, csrNumT num, logic [dataWidth-1:0] expected);
        logic [dataWidth-1:0] field;
        string fieldName;
        fieldName = "";
        field = '0;
        case (num)
            csrNumMstatus:  begin field = got.mstatus; fieldName = "csrWhole.mstatus"; end
            csrNumMip:      begin field = got.mip; fieldName = "csrWhole.mip"; end
            csrNumMie:      begin field = got.mie; fieldName = "csrWhole.mie"; end
            csrNumMcause:   begin field = got.mcause; fieldName = "csrWhole.mcause"; end
            csrNumMtvec:    begin field = got.mtvec; fieldName = "csrWhole.mtvec"; end
            csrNumMtval:    begin field = got.mtval; fieldName = "csrWhole.mtval"; end
            csrNumMepc:     begin field = got.mepc; fieldName = "csrWhole.mepc"; end
            csrNumMscratch: begin field = got.mscratch; fieldName = "csrWhole.mscratch"; end
            csrNumMcycle:   begin field = got.mcycle; fieldName = "csrWhole.mcycle"; end
            csrNumMinstret: begin field = got.minstret; fieldName = "csrWhole.minstret"; end
            default:        fieldName = "";
        endcase
        if (fieldName != "" && field !== expected) begin
            reportMismatch(fieldName, field, expected);
        end
    endtask

    task automatic compareCode(extIntCodeT got, extIntCodeT expected);
        if (got !== expected) begin
            reportMismatch("extIntCodeOut", 32'(got), 32'(expected));
        end
    endtask

    task automatic loadTrace();
        int fd;
        int count;
        logic [127:0] token;
        logic [127:0] dataToken;
        logic [127:0] expToken;
        logic [2047:0] skipped;
        logic [31:0] weVal, opVal, numVal, dataVal, tvVal, causeVal, pcVal, daddrVal;
        logic [31:0] cnVal, iwVal, iraVal, rtVal, reVal, evVal;
        logic [31:0] expVal, tgtVal, ivVal, icVal, iaddrVal;
        traceLineT entry;
        fd = $fopen(traceFile, "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            $display("tests failed");
            $fatal(1, "Missing trace file");
        end
        while ($fscanf(fd, "%s", token) == 1) begin
            if (token == "#") begin
                count = $fgets(skipped, fd);
            end else begin
                count = $fscanf(fd, "%h %h %s %h %h %h %h %h %h %h %h %h %h %s %h %h %h %h",
                                opVal, numVal, dataToken, tvVal, causeVal, pcVal, daddrVal,
                                cnVal, iwVal, iraVal, rtVal, reVal, evVal,
                                expToken, tgtVal, ivVal, icVal, iaddrVal);
                if (count != 18) begin
                    $display("Trace line %0d has missing or malformed fields", trace.size());
                    $display("tests failed");
                    $fatal(1, "Bad trace file");
                end
                count = $sscanf(token, "%h", weVal);
                dataVal = '0;
                expVal = '0;
                entry = '0;
                entry.dataIsRnd = (dataToken == "rnd");
                if (!entry.dataIsRnd) begin
                    count = $sscanf(dataToken, "%h", dataVal);
                end
                entry.expReadIsRnd = (expToken == "rnd");
                if (!entry.expReadIsRnd) begin
                    count = $sscanf(expToken, "%h", expVal);
                end
                entry.csrReq.we = weVal[0];
                entry.csrReq.op = csrOpT'(opVal[1:0]);
                entry.csrReq.num = numVal[11:0];
                entry.csrReq.writeData = dataVal;
                entry.trapReq.valid = tvVal[0];
                entry.trapReq.cause = execStateT'(causeVal[3:0]);
                entry.trapReq.pc = pcVal;
                entry.trapReq.dataAddr = daddrVal;
                entry.commitNum = cnVal[1:0];
                entry.intWindow = iwVal[0];
                entry.intRetAddr = iraVal;
                entry.reqTimerInt = rtVal[0];
                entry.reqExtInt = reVal[0];
                entry.perfEvent = evVal[3:0];
                entry.expRead = expVal;
                entry.expTarget = tgtVal;
                entry.expInt.valid = ivVal[0];
                entry.expInt.code = icVal[3:0];
                entry.expInt.retAddr = iaddrVal;
                trace.push_back(entry);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        traceLineT line;
        logic [31:0] operand;
        logic [31:0] expRead;
        logic [31:0] pendingResult;
        extIntCodeT nextCode;
        extIntCodeT prevCode;
        clk = 1'b0;
        rstN = 1'b0;
        csrReq = '0;
        trapReq = '0;
        commitNum = '0;
        intWindow = 1'b0;
        intRetAddr = '0;
        reqTimerInt = 1'b0;
        reqExtInt = 1'b0;
        extIntCode = '0;
        perfEvent = '0;
        pendingResult = '0;
        prevCode = '0;
        loadTrace();
        traceLoaded = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < trace.size(); i++) begin
            lineIndex = i;
            line = trace[i];
            expRead = line.expReadIsRnd ? pendingResult : line.expRead;
            // Expected value of a random write shows up on a later read
            if (line.dataIsRnd) begin
                drawRandomWord(operand);
                line.csrReq.writeData = operand;
                pendingResult = expectedWriteResult(line.csrReq.op, line.csrReq.num,
                                                    expRead, operand);
            end
            drawRandomCode(nextCode);
            @(posedge clk);
            csrReq <= line.csrReq;
            trapReq <= line.trapReq;
            commitNum <= line.commitNum;
            intWindow <= line.intWindow;
            intRetAddr <= line.intRetAddr;
            reqTimerInt <= line.reqTimerInt;
            reqExtInt <= line.reqExtInt;
            extIntCode <= nextCode;
            perfEvent <= line.perfEvent;
            @(negedge clk);
            compareData("readData", readData, expRead);
            compareAddr(targetAddr, line.expTarget);
            compareInt(intTaken, line.expInt);
            compareWhole(csrWhole, line.csrReq.num, expRead);
            // One register stage between the code input and its output
            compareCode(extIntCodeOut, prevCode);
            prevCode = nextCode;
        end
        $display("all tests passed");
        $finish;
    end

    // Twice the reset plus trace length
    initial begin
        longint timeLimit;
        wait (traceLoaded);
        timeLimit = 2 * (trace.size() + resetCycles) * clkPeriod;
        #(timeLimit);
        $display("Timeout: the trace did not finish within %0d time units", timeLimit);
        $display("tests failed");
        $fatal(1, "Run hung");
    end

endmodule

`default_nettype wire

/* source/csrSubsystem.sv */
/*
 * Top level of the CSR subsystem.
 * Connects the interrupt arbiter and the event counters to the CSR file.
 */
`default_nettype none

module csrSubsystem
    import csrPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire csrReqT               csrReq,
    input  wire trapReqT              trapReq,
    input  wire commitCountT          commitNum,
    input  wire logic                 intWindow,
    input  wire logic [dataWidth-1:0] intRetAddr,
    input  wire logic                 reqTimerInt,
    input  wire logic                 reqExtInt,
    input  wire extIntCodeT           extIntCode,
    input  wire perfEventT            perfEvent,
    output logic [dataWidth-1:0]      readData,
    output logic [dataWidth-1:0]      targetAddr,
    output csrBodyT                   csrWhole,
    output intReqT                    intTaken,
    output extIntCodeT                extIntCodeOut
);

    perfCountT perfCount;
    intReqT intReq;
    csrBodyT csrState;

    perfCounterBank i_perfCounterBank (
        .clk       (clk),
        .rstN      (rstN),
        .perfEvent (perfEvent),
        .perfCount (perfCount)
    );

    // Sees the registered mip, one cycle after the request lines
    interruptArbiter i_interruptArbiter (
        .csrWhole   (csrState),
        .intWindow  (intWindow),
        .intRetAddr (intRetAddr),
        .intReq     (intReq)
    );

    csrFile i_csrFile (
        .clk           (clk),
        .rstN          (rstN),
        .csrReq        (csrReq),
        .trapReq       (trapReq),
        .intReq        (intReq),
        .commitNum     (commitNum),
        .reqTimerInt   (reqTimerInt),
        .reqExtInt     (reqExtInt),
        .extIntCode    (extIntCode),
        .perfCount     (perfCount),
        .readData      (readData),
        .targetAddr    (targetAddr),
        .csrWhole      (csrState),
        .extIntCodeOut (extIntCodeOut)
    );

    assign csrWhole = csrState;
    assign intTaken = intReq;

endmodule

`default_nettype wire

/* source/perfCounterBank.sv */
/*
 * Four wrapping event counters for the mhpmcounter3 to mhpmcounter6 CSRs.
 * Each counter advances by one on a cycle in which its strobe is high.
 */
`default_nettype none

module perfCounterBank
    import csrPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rstN,
    input  wire perfEventT perfEvent,
    output perfCountT      perfCount
);

    perfCountT countReg;
    perfCountT countNext;

    always_comb begin
        countNext = countReg;
        if (perfEvent.loadMiss) begin
            countNext.loadMiss = countReg.loadMiss + dataWidth'(1);
        end
        if (perfEvent.storeMiss) begin
            countNext.storeMiss = countReg.storeMiss + dataWidth'(1);
        end
        if (perfEvent.icMiss) begin
            countNext.icMiss = countReg.icMiss + dataWidth'(1);
        end
        // Mispredicted branches
        if (perfEvent.branchMiss) begin
            countNext.branchMiss = countReg.branchMiss + dataWidth'(1);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            countReg <= '0;
        end else begin
            countReg <= countNext;
        end
    end

    assign perfCount = countReg;

endmodule

`default_nettype wire

/* source/interruptArbiter.sv */
/*
 * Decides whether an interrupt is taken in the current commit window.
 * Looks only at mstatus, mie and mip; external wins over timer.
 */
`default_nettype none

module interruptArbiter
    import csrPkg::*;
(
    input  wire csrBodyT              csrWhole,
    input  wire logic                 intWindow,
    input  wire logic [dataWidth-1:0] intRetAddr,
    output intReqT                    intReq
);

    logic timerPending;
    logic extPending;
    logic anyPending;
    interruptCodeT winCode;

    // Per-source enable and pending, gated by the global enable
    always_comb begin
        timerPending = csrWhole.mstatus.mie
                     & csrWhole.mie.mtie
                     & csrWhole.mip.mtip;
        extPending = csrWhole.mstatus.mie
                   & csrWhole.mie.meie
                   & csrWhole.mip.meip;
        anyPending = timerPending | extPending;
    end

    // Fixed priority
    always_comb begin
        if (extPending) begin
            winCode = intCodeMachineExternal;
        end else begin
            winCode = intCodeMachineTimer;
        end
    end

    // Taken only where the pipeline can accept it
    always_comb begin
        intReq.valid = anyPending & intWindow;
        intReq.code = winCode;
        intReq.retAddr = intRetAddr;
    end

endmodule

`default_nettype wire

/* source/csrFile.sv */
/*
 * Machine-mode CSR register body with read decode and write/set/clear operations.
 * Applies interrupt entry, trap entry and MRET, and picks the front-end jump target.
 * One action per cycle: interrupt before trap before CSR operation.
 */
`default_nettype none

module csrFile
    import csrPkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire csrReqT               csrReq,
    input  wire trapReqT              trapReq,
    input  wire intReqT               intReq,
    input  wire commitCountT          commitNum,
    input  wire logic                 reqTimerInt,
    input  wire logic                 reqExtInt,
    input  wire extIntCodeT           extIntCode,
    input  wire perfCountT            perfCount,
    output logic [dataWidth-1:0]      readData,
    output logic [dataWidth-1:0]      targetAddr,
    output csrBodyT                   csrWhole,
    output extIntCodeT                extIntCodeOut
);

    csrBodyT csrReg;
    csrBodyT csrNext;
    logic [dataWidth-1:0] readValue;
    logic [dataWidth-1:0] writeValue;
    commitCountT regCommitNum;

    // The interrupt fires a cycle after the request is latched in mip,
    // so the external source code is delayed to match
    extIntCodeT extIntCodeReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            csrReg <= '0;
            regCommitNum <= '0;
            extIntCodeReg <= '0;
        end else begin
            csrReg <= csrNext;
            regCommitNum <= commitNum;
            extIntCodeReg <= extIntCode;
        end
    end

    // Read decode
    always_comb begin
        case (csrReq.num)
            csrNumMstatus:      readValue = csrReg.mstatus;
            csrNumMip:          readValue = csrReg.mip;
            csrNumMie:          readValue = csrReg.mie;
            csrNumMcause:       readValue = csrReg.mcause;
            csrNumMtvec:        readValue = csrReg.mtvec;
            csrNumMtval:        readValue = csrReg.mtval;
            csrNumMepc:         readValue = csrReg.mepc;
            csrNumMscratch:     readValue = csrReg.mscratch;
            csrNumMcycle:       readValue = csrReg.mcycle;
            csrNumMinstret:     readValue = csrReg.minstret;
            csrNumMhpmcounter3: readValue = perfCount.loadMiss;
            csrNumMhpmcounter4: readValue = perfCount.storeMiss;
            csrNumMhpmcounter5: readValue = perfCount.icMiss;
            csrNumMhpmcounter6: readValue = perfCount.branchMiss;
            default:            readValue = '0;
        endcase
    end

    // Operand merged with the old value
    always_comb begin
        case (csrReq.op)
            csrOpWrite: writeValue = csrReq.writeData;
            csrOpSet:   writeValue = readValue | csrReq.writeData;
            csrOpClear: writeValue = readValue & ~csrReq.writeData;
            default:    writeValue = csrReq.writeData;
        endcase
    end

    always_comb begin
        csrNext = csrReg;

        // Counters first, so a software write below overrides them
        csrNext.mcycle = csrReg.mcycle + dataWidth'(1);
        csrNext.minstret = csrReg.minstret + dataWidth'(regCommitNum);

        if (intReq.valid) begin
            csrNext.mstatus.mpie = csrReg.mstatus.mie;
            csrNext.mstatus.mie = 1'b0;
            csrNext.mepc = intReq.retAddr;
            csrNext.mtval = intReq.retAddr;
            csrNext.mcause.isInterrupt = 1'b1;
            csrNext.mcause.code.interruptCode = intReq.code;
        end else if (trapReq.valid) begin
            if (trapReq.cause == trapMret) begin
                // Return restores the saved enable
                csrNext.mstatus.mie = csrReg.mstatus.mpie;
            end else begin
                csrNext.mstatus.mpie = csrReg.mstatus.mie;
                csrNext.mstatus.mie = 1'b0;
                csrNext.mepc = trapReq.pc;
                csrNext.mtval = trapReq.dataAddr;
                csrNext.mcause.isInterrupt = 1'b0;
                csrNext.mcause.code.trapCode = trapCodeFromExec(trapReq.cause);
            end
        end else if (csrReq.we) begin
            case (csrReq.num)
                csrNumMstatus:  csrNext.mstatus = mstatusT'(writeValue);
                csrNumMie:      csrNext.mie = mieT'(writeValue);
                csrNumMcause:   csrNext.mcause = mcauseT'(writeValue);
                csrNumMtvec:    csrNext.mtvec = mtvecT'(writeValue);
                csrNumMtval:    csrNext.mtval = writeValue;
                // mepc is always halfword aligned
                csrNumMepc:     csrNext.mepc = {writeValue[dataWidth-1:1], 1'b0};
                csrNumMscratch: csrNext.mscratch = writeValue;
                csrNumMcycle:   csrNext.mcycle = writeValue;
                csrNumMinstret: csrNext.minstret = writeValue;
                // mip and unknown numbers are read only here
                default:        ;
            endcase
        end

        // Pending bits follow the request lines
        csrNext.mip.mtip = reqTimerInt;
        csrNext.mip.meip = reqExtInt;
    end

    // Jump target for the front end
    always_comb begin
        if (trapReq.cause == trapMret) begin
            targetAddr = csrReg.mepc;
        end else begin
            targetAddr = {csrReg.mtvec.base, mtvecBasePadding};
        end
    end

    assign readData = readValue;
    assign csrWhole = csrReg;
    assign extIntCodeOut = extIntCodeReg;

endmodule

`default_nettype wire

/* source/csrPkg.sv */
/*
 * Shared types and constants of the machine-mode CSR subsystem.
 * Holds the CSR numbers, operation and execution codes and the register layouts.
 * Imported by every RTL module and by the testbench.
 */
`default_nettype none

package csrPkg;

    localparam int dataWidth = 32;

    typedef logic [11:0] csrNumT;

    // Machine-mode CSR numbers
    localparam csrNumT csrNumMstatus = 12'h300;
    localparam csrNumT csrNumMie = 12'h304;
    localparam csrNumT csrNumMtvec = 12'h305;
    localparam csrNumT csrNumMscratch = 12'h340;
    localparam csrNumT csrNumMepc = 12'h341;
    localparam csrNumT csrNumMcause = 12'h342;
    localparam csrNumT csrNumMtval = 12'h343;
    localparam csrNumT csrNumMip = 12'h344;
    localparam csrNumT csrNumMcycle = 12'hB00;
    localparam csrNumT csrNumMinstret = 12'hB02;
    localparam csrNumT csrNumMhpmcounter3 = 12'hB03;
    localparam csrNumT csrNumMhpmcounter4 = 12'hB04;
    localparam csrNumT csrNumMhpmcounter5 = 12'hB05;
    localparam csrNumT csrNumMhpmcounter6 = 12'hB06;

    // Low two bits of the jump target in direct mode
    localparam logic [1:0] mtvecBasePadding = 2'b00;

    typedef enum logic [1:0] {
        csrOpWrite = 2'd0,
        csrOpSet   = 2'd1,
        csrOpClear = 2'd2
    } csrOpT;

    typedef enum logic [3:0] {
        trapEcall            = 4'd0,
        trapEbreak           = 4'd1,
        trapMret             = 4'd2,
        faultLoadMisaligned  = 4'd3,
        faultLoadViolation   = 4'd4,
        faultStoreMisaligned = 4'd5,
        faultStoreViolation  = 4'd6,
        faultInsnIllegal     = 4'd7,
        faultInsnViolation   = 4'd8,
        faultInsnMisaligned  = 4'd9
    } execStateT;

    typedef logic [3:0] trapCodeT;
    typedef logic [3:0] interruptCodeT;
    typedef logic [3:0] extIntCodeT;
    typedef logic [1:0] commitCountT;

    localparam interruptCodeT intCodeMachineTimer = 4'd7;
    localparam interruptCodeT intCodeMachineExternal = 4'd11;

    // Exception cause numbers of the privileged spec
    function automatic trapCodeT trapCodeFromExec(execStateT state);
        trapCodeT code;
        case (state)
            trapEcall:            code = 4'd11;
            trapEbreak:           code = 4'd3;
            faultLoadMisaligned:  code = 4'd4;
            faultLoadViolation:   code = 4'd5;
            faultStoreMisaligned: code = 4'd6;
            faultStoreViolation:  code = 4'd7;
            faultInsnIllegal:     code = 4'd2;
            faultInsnViolation:   code = 4'd1;
            faultInsnMisaligned:  code = 4'd0;
            default:              code = 4'd0;
        endcase
        return code;
    endfunction

    // Same four bits, read as an interrupt or as a trap
    typedef union packed {
        trapCodeT      trapCode;
        interruptCodeT interruptCode;
    } mcauseCodeU;

    typedef struct packed {
        logic        isInterrupt;
        logic [26:0] zero;
        mcauseCodeU  code;
    } mcauseT;

    typedef struct packed {
        logic [23:0] reserved2;
        logic        mpie;
        logic [2:0]  reserved1;
        logic        mie;
        logic [2:0]  reserved0;
    } mstatusT;

    typedef struct packed {
        logic [19:0] reserved2;
        logic        meip;
        logic [2:0]  reserved1;
        logic        mtip;
        logic [6:0]  reserved0;
    } mipT;

    typedef struct packed {
        logic [19:0] reserved2;
        logic        meie;
        logic [2:0]  reserved1;
        logic        mtie;
        logic [6:0]  reserved0;
    } mieT;

    typedef struct packed {
        logic [29:0] base;
        logic [1:0]  mode;
    } mtvecT;

    typedef struct packed {
        mstatusT                mstatus;
        mipT                    mip;
        mieT                    mie;
        mcauseT                 mcause;
        mtvecT                  mtvec;
        logic [dataWidth-1:0]   mtval;
        logic [dataWidth-1:0]   mepc;
        logic [dataWidth-1:0]   mscratch;
        logic [dataWidth-1:0]   mcycle;
        logic [dataWidth-1:0]   minstret;
    } csrBodyT;

    typedef struct packed {
        logic                 we;
        csrOpT                op;
        csrNumT               num;
        logic [dataWidth-1:0] writeData;
    } csrReqT;

    typedef struct packed {
        logic                 valid;
        execStateT            cause;
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] dataAddr;
    } trapReqT;

    typedef struct packed {
        logic                 valid;
        interruptCodeT        code;
        logic [dataWidth-1:0] retAddr;
    } intReqT;

    typedef struct packed {
        logic loadMiss;
        logic storeMiss;
        logic icMiss;
        logic branchMiss;
    } perfEventT;

    typedef struct packed {
        logic [dataWidth-1:0] loadMiss;
        logic [dataWidth-1:0] storeMiss;
        logic [dataWidth-1:0] icMiss;
        logic [dataWidth-1:0] branchMiss;
    } perfCountT;

endpackage

`default_nettype wire
